/* project.f */
logic/ac97_frame_pkg.sv
logic/codec_reg_pkg.sv
logic/ac97_frame_timer.sv
logic/ac97_command_sequencer.sv
logic/ac97_slot_serializer.sv
logic/ac97_slot_capture.sv
logic/button_debounce.sv
logic/volume_control.sv
logic/ac97_audio_top.sv
tb/tb_ac97_audio.sv

/* tb/tb_ac97_audio.sv */
module tb_ac97_audio;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int cycle_limit = 30000;

  // one decoded outgoing frame
  typedef struct packed {
    logic [15:0] tags;
    logic [19:0] slot1;
    logic [19:0] slot2;
    logic [19:0] slot3;
    logic [19:0] slot4;
    logic        tail_clear;
  } frame_fields_t;

  logic clock;
  logic reset;
  logic vol_up;
  logic vol_down;
  logic [7:0] pcm_out;
  logic [7:0] pcm_in;
  logic sample_strobe;
  logic codec_reset_n;
  logic ac97_sync;
  logic ac97_sdata_out;
  logic ac97_sdata_in;

  // decoder state
  int since_reset;
  int cycles;
  logic locked;
  logic [7:0] pos_next;
  int cur_frame;
  logic [255:0] collect;
  logic done_valid;
  int done_index;
  logic [255:0] done_bits;
  frame_fields_t fields;
  // stimulus bookkeeping
  logic [7:0] play_bytes [0:255];
  logic [19:0] cap_cur;
  logic known;
  logic [4:0] exp_att;

  ac97_audio_top #(.debounce_cycles(8)) dut (
    .clock(clock),
    .reset(reset),
    .vol_up(vol_up),
    .vol_down(vol_down),
    .pcm_out(pcm_out),
    .pcm_in(pcm_in),
    .sample_strobe(sample_strobe),
    .codec_reset_n(codec_reset_n),
    .ac97_sync(ac97_sync),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in)
  );

  always #10 clock = ~clock;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  // codec register loop, address then data
  function automatic logic [23:0] expected_command(input int step, input logic [4:0] att);
    case (step)
      3: return {codec_reg_pkg::reg_master_headphone, 3'b000, att, 3'b000, att};
      5: return {codec_reg_pkg::reg_pcm_volume, codec_reg_pkg::pcm_volume_value};
      6: return {codec_reg_pkg::reg_record_select, codec_reg_pkg::record_source_mic};
      7: return {codec_reg_pkg::reg_record_gain, codec_reg_pkg::record_gain_max};
      9: return {codec_reg_pkg::reg_mic_gain, codec_reg_pkg::mic_boost_value};
      10: return {codec_reg_pkg::reg_beep_volume, codec_reg_pkg::beep_off_value};
      11: return {codec_reg_pkg::reg_general_purpose, codec_reg_pkg::pcm_bypass_value};
      default: return {codec_reg_pkg::reg_read_id, 16'h0000};
    endcase
  endfunction

  // address and data left justified in slots 1 and 2
  function automatic logic [39:0] command_slot_pair(input logic [23:0] cmd);
    return {cmd[23:16], 12'h000, cmd[15:0], 4'h0};
  endfunction

  // slot word from frame bits, MSB first
  function automatic logic [19:0] slot_word(input logic [255:0] bits, input int first);
    logic [19:0] w;
    for (int j = 0; j < 20; j++) begin
      w[19-j] = bits[first+j];
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // frame decoder
  ////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    int this_pos;
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      stop_with_error("timeout: run did not finish within the cycle limit");
    end
    since_reset = reset ? 0 : since_reset + 1;
    done_valid = 1'b0;
    if (!locked && ac97_sync) begin
      locked = 1'b1;
      this_pos = 0;
      cur_frame = -1;
    end else begin
      this_pos = int'(pos_next);
    end
    if (locked) begin
      if (this_pos == 0) begin
        collect[255] = ac97_sdata_out;
        if (cur_frame >= 0) begin
          done_bits = collect;
          done_index = cur_frame;
          done_valid = 1'b1;
          fields.tags = collect[15:0];
          fields.slot1 = slot_word(collect, 16);
          fields.slot2 = slot_word(collect, 36);
          fields.slot3 = slot_word(collect, 56);
          fields.slot4 = slot_word(collect, 76);
          fields.tail_clear = (collect[255:96] == '0);
        end
        cur_frame = cur_frame + 1;
      end else begin
        collect[this_pos-1] = ac97_sdata_out;
      end
      pos_next = 8'(this_pos + 1);
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  codec_delay_low: assert property (@(posedge clock) disable iff (reset)
    (since_reset < 1024) |-> (!codec_reset_n && !ac97_sync))
    else stop_with_error("codec reset or sync released before 1024 clocks");
  codec_delay_high: assert property (@(posedge clock) disable iff (reset)
    (since_reset >= 1024) |-> codec_reset_n)
    else stop_with_error("codec reset still low after 1024 clocks");
  sync_shape: assert property (@(posedge clock) disable iff (reset)
    locked |-> (ac97_sync == (pos_next <= 8'd15)))
    else stop_with_error($sformatf("** Error: ac97_sync = %h at position %h",
      $sampled(ac97_sync), $sampled(pos_next)));
  strobe_place: assert property (@(posedge clock) disable iff (reset)
    locked |-> (sample_strobe == (pos_next == 8'd128)))
    else stop_with_error($sformatf("** Error: sample_strobe = %h at position %h",
      $sampled(sample_strobe), $sampled(pos_next)));
  no_early_strobe: assert property (@(posedge clock) disable iff (reset)
    !locked |-> !sample_strobe)
    else stop_with_error("sample strobe fired before the first frame");
  first_frame_empty: assert property (@(posedge clock)
    (done_valid && done_index == 0) |-> (done_bits == '0))
    else stop_with_error("frame 0 carries nonzero bits");
  tags_set: assert property (@(posedge clock)
    (done_valid && done_index > 0) |-> (fields.tags == 16'h001f))
    else stop_with_error($sformatf("** Error: tags = %h, expected %h", $sampled(fields.tags),
      16'h001f));
  tail_zero: assert property (@(posedge clock)
    (done_valid && done_index > 0) |-> fields.tail_clear)
    else stop_with_error("bits after slot 4 are not zero");
  right_copy: assert property (@(posedge clock)
    (done_valid && done_index > 0) |-> (fields.slot4 == fields.slot3))
    else stop_with_error($sformatf("** Error: slot4 = %h, expected %h",
      $sampled(fields.slot4), $sampled(fields.slot3)));
  command_slots: assert property (@(posedge clock)
    (done_valid && done_index > 0 && known) |->
      ({fields.slot1, fields.slot2} ==
       command_slot_pair(expected_command(done_index % 16, exp_att))))
    else stop_with_error($sformatf("** Error: slot1/slot2 = %h/%h, expected command %h",
      $sampled(fields.slot1), $sampled(fields.slot2),
      expected_command($sampled(done_index) % 16, $sampled(exp_att))));
  playback: assert property (@(posedge clock)
    (done_valid && done_index > 0) |->
      (fields.slot3 == {play_bytes[done_index-1], 12'h000}))
    else stop_with_error($sformatf("** Error: slot3 = %h, expected %h", $sampled(fields.slot3),
      {play_bytes[$sampled(done_index)-1], 12'h000}));
  capture: assert property (@(posedge clock) disable iff (reset)
    (locked && sample_strobe) |-> (pcm_in == cap_cur[19:12]))
    else stop_with_error($sformatf("** Error: pcm_in = %h, expected %h", $sampled(pcm_in),
      $sampled(cap_cur[19:12])));

  ////////////////////////////////////////////////////////////
  // codec side, driven on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    if (locked && pos_next == 8'd1) begin
      cap_cur = 20'($urandom);
    end
    if (locked && pos_next >= 8'd56 && pos_next <= 8'd75) begin
      ac97_sdata_in = cap_cur[75 - int'(pos_next)];
    end else begin
      ac97_sdata_in = 1'b0;
    end
    if (locked && sample_strobe) begin
      pcm_out = 8'($urandom);
      play_bytes[cur_frame] = pcm_out;
    end
  end

  task automatic press_button(input bit up_button, input int hold_cycles);
    if (up_button) begin
      vol_up = 1'b1;
    end else begin
      vol_down = 1'b1;
    end
    repeat (hold_cycles) @(negedge clock);
    vol_up = 1'b0;
    vol_down = 1'b0;
    repeat (16) @(negedge clock);
  endtask

  // new attenuation counts from the frame that opens at the next sync
  task automatic settle_attenuation(input logic [4:0] att);
    repeat (20) @(negedge clock);
    exp_att = att;
    do @(negedge clock); while (pos_next != 8'd2);
    known = 1'b1;
  endtask

  task automatic wait_headphone_check;
    do @(negedge clock); while (!(done_valid && known && done_index % 16 == 3));
    // the check fires on the following rising edge
    @(negedge clock);
  endtask

  initial begin
    void'($urandom(58157));
    clock = 1'b0;
    reset = 1'b1;
    vol_up = 1'b0;
    vol_down = 1'b0;
    pcm_out = 8'h00;
    ac97_sdata_in = 1'b0;
    since_reset = 0;
    cycles = 0;
    locked = 1'b0;
    pos_next = 8'd0;
    cur_frame = -1;
    done_valid = 1'b0;
    done_index = 0;
    known = 1'b1;
    exp_att = 5'd23;
    repeat (4) @(negedge clock);
    reset = 1'b0;
    // command loop at reset volume over two passes
    do @(negedge clock); while (!(done_valid && done_index == 32));
    @(negedge clock);
    // a short glitch, then three real presses
    known = 1'b0;
    press_button(1'b1, 4);
    repeat (3) press_button(1'b1, 16);
    settle_attenuation(5'd20);
    wait_headphone_check();
    known = 1'b0;
    repeat (40) press_button(1'b1, 16);
    settle_attenuation(5'd0);
    wait_headphone_check();
    known = 1'b0;
    press_button(1'b0, 16);
    settle_attenuation(5'd1);
    wait_headphone_check();
    $display("Done: no errors");
    $finish;
  end

endmodule

/* logic/ac97_audio_top.sv */
module ac97_audio_top #(
  parameter int debounce_cycles = codec_reg_pkg::debounce_cycles_default
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      vol_up,
  input  logic                      vol_down,
  input  ac97_frame_pkg::pcm_byte_t pcm_out,
  output ac97_frame_pkg::pcm_byte_t pcm_in,
  output logic                      sample_strobe,
  output logic                      codec_reset_n,
  output logic                      ac97_sync,
  output logic                      ac97_sdata_out,
  input  logic                      ac97_sdata_in
);

  ac97_frame_pkg::bit_pos_t     bit_pos;
  logic                         frame_running;
  codec_reg_pkg::ac97_command_t command;
  logic                         command_valid;
  codec_reg_pkg::volume_t       volume;
  // playback byte held between strobes
  ac97_frame_pkg::pcm_byte_t    play_byte;
  ac97_frame_pkg::out_frame_t   out_frame;

  always_ff @(posedge clock) begin
    if (sample_strobe) begin
      play_byte <= pcm_out;
    end
  end

  // 8-bit sample padded out to the 20-bit slot
  assign out_frame.cmd_valid = command_valid;
  assign out_frame.command   = command;
  assign out_frame.left      = {play_byte,
    {(ac97_frame_pkg::slot_width - $bits(play_byte)){1'b0}}};

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  ac97_frame_timer frame_timer (
    .clock(clock),
    .reset(reset),
    .codec_reset_n(codec_reset_n),
    .bit_pos(bit_pos),
    .frame_running(frame_running),
    .ac97_sync(ac97_sync),
    .sample_strobe(sample_strobe)
  );

  ac97_command_sequencer command_sequencer (
    .clock(clock),
    .reset(reset),
    .sample_strobe(sample_strobe),
    .volume(volume),
    .command(command),
    .command_valid(command_valid)
  );

  ac97_slot_serializer slot_serializer (
    .clock(clock),
    .reset(reset),
    .bit_pos(bit_pos),
    .frame_running(frame_running),
    .frame(out_frame),
    .ac97_sdata_out(ac97_sdata_out)
  );

  ac97_slot_capture slot_capture (
    .clock(clock),
    .reset(reset),
    .bit_pos(bit_pos),
    .ac97_sdata_in(ac97_sdata_in),
    .pcm_in(pcm_in)
  );

  volume_control #(
    .stable_cycles(debounce_cycles)
  ) volume_ctrl (
    .clock(clock),
    .reset(reset),
    .vol_up(vol_up),
    .vol_down(vol_down),
    .volume(volume)
  );

endmodule

/* logic/volume_control.sv */
module volume_control #(
  parameter int stable_cycles = codec_reg_pkg::debounce_cycles_default
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   vol_up,
  input  logic                   vol_down,
  output codec_reg_pkg::volume_t volume
);

  // debounced levels and their previous values
  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;
  logic up_rise;
  logic down_rise;

  ////////////////////////////////////////////////////////////
  // button cleanup
  ////////////////////////////////////////////////////////////

  button_debounce #(
    .stable_cycles(stable_cycles)
  ) up_debounce (
    .clock(clock),
    .reset(reset),
    .noisy(vol_up),
    .clean(up_clean)
  );

  button_debounce #(
    .stable_cycles(stable_cycles)
  ) down_debounce (
    .clock(clock),
    .reset(reset),
    .noisy(vol_down),
    .clean(down_clean)
  );

  // one step per press
  assign up_rise   = up_clean & ~up_prev;
  assign down_rise = down_clean & ~down_prev;

  always_ff @(posedge clock) begin
    if (reset) begin
      volume    <= codec_reg_pkg::volume_reset_value;
      up_prev   <= up_clean;
      down_prev <= down_clean;
    end else begin
      up_prev   <= up_clean;
      down_prev <= down_clean;
      // down has priority when both rise together
      if (down_rise && (volume != '0)) begin
        volume <= volume - 1'b1;
      end else if (up_rise && (volume != codec_reg_pkg::volume_max)) begin
        volume <= volume + 1'b1;
      end
    end
  end

  // each step moves one count and never wraps past 0 or volume_max
  volume_steps_by_one: assert property (@(posedge clock) disable iff (reset)
    (volume != $past(volume)) |->
      ((6'(volume) == 6'($past(volume)) + 6'd1) ||
       (6'(volume) + 6'd1 == 6'($past(volume)))))
    else $error("volume wrapped or jumped by more than one step");

endmodule

/* logic/button_debounce.sv */
module button_debounce #(
  parameter int stable_cycles = codec_reg_pkg::debounce_cycles_default
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int count_bits = $clog2(stable_cycles + 1);

  // clocks since the last change
  logic [count_bits-1:0] stable_count;
  // last level seen on the input
  logic last_noisy;

  always_ff @(posedge clock) begin
    if (reset) begin
      stable_count <= '0;
      last_noisy   <= noisy;
      clean        <= noisy;
    end else if (noisy != last_noisy) begin
      // any edge restarts the wait
      last_noisy   <= noisy;
      stable_count <= '0;
    end else if (stable_count == count_bits'(stable_cycles)) begin
      // quiet long enough, pass it on
      clean <= last_noisy;
    end else begin
      stable_count <= stable_count + 1'b1;
    end
  end

endmodule

/* logic/ac97_slot_capture.sv */
module ac97_slot_capture (
  input  logic                      clock,
  input  logic                      reset,
  input  ac97_frame_pkg::bit_pos_t  bit_pos,
  input  logic                      ac97_sdata_in,
  output ac97_frame_pkg::pcm_byte_t pcm_in
);

  // slot 3 word as it arrives
  ac97_frame_pkg::sample_t shift_reg;
  logic in_slot3;

  assign in_slot3 = (bit_pos >= ac97_frame_pkg::slot3_first_pos) &&
    (bit_pos < ac97_frame_pkg::slot3_first_pos + ac97_frame_pkg::slot_width);

  // msb arrives first
  always_ff @(posedge clock) begin
    if (in_slot3) begin
      shift_reg <= {shift_reg[ac97_frame_pkg::slot_width-2:0], ac97_sdata_in};
    end
  end

  ////////////////////////////////////////////////////////////
  // hold the top byte until the next frame
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      pcm_in <= '0;
    end else if (bit_pos == ac97_frame_pkg::capture_done_pos) begin
      // settled well before the strobe
      pcm_in <= shift_reg[ac97_frame_pkg::slot_width-1 -: $bits(ac97_frame_pkg::pcm_byte_t)];
    end
  end

endmodule

/* logic/ac97_slot_serializer.sv */
module ac97_slot_serializer (
  input  logic                       clock,
  input  logic                       reset,
  input  ac97_frame_pkg::bit_pos_t   bit_pos,
  input  logic                       frame_running,
  input  ac97_frame_pkg::out_frame_t frame,
  output logic                       ac97_sdata_out
);

  // control side of the latched frame
  logic frame_loaded;
  logic held_cmd_valid;
  logic frame_end;
  logic next_bit;
  // payload side
  codec_reg_pkg::ac97_command_t held_cmd;
  ac97_frame_pkg::sample_t      held_left;
  ac97_frame_pkg::sample_t      cmd_addr_slot;
  ac97_frame_pkg::sample_t      cmd_data_slot;

  // bit of a slot word for the current position, MSB first
  function automatic logic slot_bit(input ac97_frame_pkg::sample_t  word,
                                    input ac97_frame_pkg::bit_pos_t pos,
                                    input int                       first_pos);
    int idx;
    idx = first_pos + ac97_frame_pkg::slot_width - 1 - int'(pos);
    return word[idx];
  endfunction

  assign frame_end = frame_running &&
    (bit_pos == ac97_frame_pkg::bit_pos_t'(ac97_frame_pkg::frame_bits - 1));

  // address and data are left justified in their slots
  assign cmd_addr_slot = {held_cmd.address,
    {(ac97_frame_pkg::slot_width - $bits(held_cmd.address)){1'b0}}};
  assign cmd_data_slot = {held_cmd.data,
    {(ac97_frame_pkg::slot_width - $bits(held_cmd.data)){1'b0}}};

  ////////////////////////////////////////////////////////////
  // bit select by frame position
  ////////////////////////////////////////////////////////////

  always_comb begin
    next_bit = 1'b0;
    if (bit_pos <= ac97_frame_pkg::sync_last_pos) begin
      case (int'(bit_pos))
        ac97_frame_pkg::tag_frame_valid: next_bit = frame_running & frame_loaded;
        ac97_frame_pkg::tag_cmd_addr:    next_bit = held_cmd_valid;
        ac97_frame_pkg::tag_cmd_data:    next_bit = held_cmd_valid;
        ac97_frame_pkg::tag_left:        next_bit = frame_loaded;
        ac97_frame_pkg::tag_right:       next_bit = frame_loaded;
        default:                         next_bit = 1'b0;
      endcase
    end else if (bit_pos < ac97_frame_pkg::slot2_first_pos) begin
      next_bit = held_cmd_valid &
        slot_bit(cmd_addr_slot, bit_pos, ac97_frame_pkg::slot1_first_pos);
    end else if (bit_pos < ac97_frame_pkg::slot3_first_pos) begin
      next_bit = held_cmd_valid &
        slot_bit(cmd_data_slot, bit_pos, ac97_frame_pkg::slot2_first_pos);
    end else if (bit_pos < ac97_frame_pkg::slot4_first_pos) begin
      next_bit = frame_loaded &
        slot_bit(held_left, bit_pos, ac97_frame_pkg::slot3_first_pos);
    end else if (bit_pos < ac97_frame_pkg::slot4_first_pos + ac97_frame_pkg::slot_width) begin
      // right channel repeats left
      next_bit = frame_loaded &
        slot_bit(held_left, bit_pos, ac97_frame_pkg::slot4_first_pos);
    end
  end

  ////////////////////////////////////////////////////////////
  // frame latch and output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      frame_loaded   <= 1'b0;
      held_cmd_valid <= 1'b0;
      ac97_sdata_out <= 1'b0;
    end else begin
      // position k goes out while bit_pos is k+1
      ac97_sdata_out <= next_bit;
      if (frame_end) begin
        frame_loaded   <= 1'b1;
        held_cmd_valid <= frame.cmd_valid;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (frame_end) begin
      held_cmd  <= frame.command;
      held_left <= frame.left;
    end
  end

endmodule

/* logic/ac97_command_sequencer.sv */
module ac97_command_sequencer (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         sample_strobe,
  input  codec_reg_pkg::volume_t       volume,
  output codec_reg_pkg::ac97_command_t command,
  output logic                         command_valid
);

  // loop position, 16 steps
  logic [3:0] state;
  // headphone field is attenuation, not gain
  codec_reg_pkg::volume_t attenuation;
  codec_reg_pkg::ac97_command_t entry;

  assign attenuation = codec_reg_pkg::volume_max - volume;

  ////////////////////////////////////////////////////////////
  // command table
  ////////////////////////////////////////////////////////////

  always_comb begin
    // idle steps just read the vendor id
    entry.address = codec_reg_pkg::reg_read_id;
    entry.data    = 16'h0000;
    case (state)
      4'd3: begin
        // same attenuation on left and right
        entry.address = codec_reg_pkg::reg_master_headphone;
        entry.data    = {3'b000, attenuation, 3'b000, attenuation};
      end
      4'd5: begin
        entry.address = codec_reg_pkg::reg_pcm_volume;
        entry.data    = codec_reg_pkg::pcm_volume_value;
      end
      4'd6: begin
        entry.address = codec_reg_pkg::reg_record_select;
        entry.data    = codec_reg_pkg::record_source_mic;
      end
      4'd7: begin
        entry.address = codec_reg_pkg::reg_record_gain;
        entry.data    = codec_reg_pkg::record_gain_max;
      end
      4'd9: begin
        entry.address = codec_reg_pkg::reg_mic_gain;
        entry.data    = codec_reg_pkg::mic_boost_value;
      end
      4'd10: begin
        entry.address = codec_reg_pkg::reg_beep_volume;
        entry.data    = codec_reg_pkg::beep_off_value;
      end
      4'd11: begin
        // route pcm out through mix1
        entry.address = codec_reg_pkg::reg_general_purpose;
        entry.data    = codec_reg_pkg::pcm_bypass_value;
      end
      default: begin
        entry.address = codec_reg_pkg::reg_read_id;
        entry.data    = 16'h0000;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // step once per sample strobe
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= 4'd0;
      command_valid <= 1'b0;
    end else begin
      if (sample_strobe) begin
        state <= state + 1'b1;
      end
      // valid from the first pass through step 0 on
      if (state == 4'd0) begin
        command_valid <= 1'b1;
      end
    end
  end

  // one stage behind the state
  always_ff @(posedge clock) begin
    command <= entry;
  end

  // the loop only moves on a strobe
  state_moves_on_strobe: assert property (@(posedge clock) disable iff (reset)
    (state != $past(state)) |-> $past(sample_strobe))
    else $error("command sequencer stepped without a sample strobe");

endmodule

/* logic/ac97_frame_timer.sv */
module ac97_frame_timer (
  input  logic                     clock,
  input  logic                     reset,
  output logic                     codec_reset_n,
  output ac97_frame_pkg::bit_pos_t bit_pos,
  output logic                     frame_running,
  output logic                     ac97_sync,
  output logic                     sample_strobe
);

  localparam int delay_bits = $clog2(ac97_frame_pkg::codec_reset_cycles);

  // power-up delay count
  logic [delay_bits-1:0] delay_count;

  ////////////////////////////////////////////////////////////
  // codec reset delay, then free-running frame count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      delay_count   <= '0;
      codec_reset_n <= 1'b0;
      bit_pos       <= '0;
      ac97_sync     <= 1'b0;
      sample_strobe <= 1'b0;
    end else if (!codec_reset_n) begin
      // bit_pos parked at 0 while the codec waits
      if (delay_count == delay_bits'(ac97_frame_pkg::codec_reset_cycles - 1)) begin
        codec_reset_n <= 1'b1;
        // first frame opens in the same clock
        ac97_sync     <= 1'b1;
      end else begin
        delay_count <= delay_count + 1'b1;
      end
    end else begin
      // wraps from 255 back to 0
      bit_pos <= bit_pos + 1'b1;
      // sync looks one position ahead, high over 0..15
      ac97_sync <= (bit_pos == ac97_frame_pkg::bit_pos_t'(ac97_frame_pkg::frame_bits - 1)) ||
                   (bit_pos < ac97_frame_pkg::bit_pos_t'(ac97_frame_pkg::sync_last_pos));
      // one clock wide, lands on strobe_pos
      sample_strobe <=
        (bit_pos == ac97_frame_pkg::bit_pos_t'(ac97_frame_pkg::strobe_pos - 1));
    end
  end

  // frames flow once the codec is released
  assign frame_running = codec_reset_n;

  // sync must stay inside the tag slot
  sync_in_tag_slot: assert property (@(posedge clock) disable iff (reset)
    ac97_sync |-> (bit_pos <= ac97_frame_pkg::sync_last_pos))
    else $error("ac97_sync high outside the tag slot");

endmodule

/* logic/codec_reg_pkg.sv */
package codec_reg_pkg;

  // command slot pair, address then data
  typedef struct packed {
    logic [7:0]  address;
    logic [15:0] data;
  } ac97_command_t;

  ////////////////////////////////////////////////////////////
  // volume
  ////////////////////////////////////////////////////////////

  typedef logic [4:0] volume_t;
  localparam volume_t volume_max         = 5'd31;
  localparam volume_t volume_reset_value = 5'd8;

  ////////////////////////////////////////////////////////////
  // register addresses
  ////////////////////////////////////////////////////////////

  // read bit set, register 0x00
  localparam logic [7:0] reg_read_id          = 8'h80;
  localparam logic [7:0] reg_master_headphone = 8'h04;
  localparam logic [7:0] reg_pcm_volume       = 8'h18;
  localparam logic [7:0] reg_record_select    = 8'h1A;
  localparam logic [7:0] reg_record_gain      = 8'h1C;
  localparam logic [7:0] reg_mic_gain         = 8'h0E;
  localparam logic [7:0] reg_beep_volume      = 8'h0A;
  localparam logic [7:0] reg_general_purpose  = 8'h20;

  ////////////////////////////////////////////////////////////
  // fixed data words
  ////////////////////////////////////////////////////////////

  localparam logic [15:0] pcm_volume_value  = 16'h0808;
  // source code 0 in both channel fields
  localparam logic [15:0] record_source_mic = 16'h0000;
  localparam logic [15:0] record_gain_max   = 16'h0F0F;
  // +20 dB boost
  localparam logic [15:0] mic_boost_value   = 16'h8048;
  localparam logic [15:0] beep_off_value    = 16'h0000;
  localparam logic [15:0] pcm_bypass_value  = 16'h8000;

  // about 10 ms at 27 MHz
  localparam int debounce_cycles_default = 270000;

endpackage

/* logic/ac97_frame_pkg.sv */
package ac97_frame_pkg;

  ////////////////////////////////////////////////////////////
  // frame geometry
  ////////////////////////////////////////////////////////////

  // one bit clock per frame bit
  localparam int frame_bits = 256;
  typedef logic [$clog2(frame_bits)-1:0] bit_pos_t;

  // sync covers the whole tag slot
  localparam int sync_last_pos = 15;

  // data slots are 20 bits, MSB first
  localparam int slot_width      = 20;
  localparam int slot1_first_pos = 16;
  localparam int slot2_first_pos = 36;
  localparam int slot3_first_pos = 56;
  localparam int slot4_first_pos = 76;

  // slot 0 tag bit positions
  localparam int tag_frame_valid = 0;
  localparam int tag_cmd_addr    = 1;
  localparam int tag_cmd_data    = 2;
  localparam int tag_left        = 3;
  localparam int tag_right       = 4;

  // user side timing inside the frame
  localparam int strobe_pos       = 128;
  localparam int capture_done_pos = 76;

  // codec held in reset this long after power-up
  localparam int codec_reset_cycles = 1024;

  ////////////////////////////////////////////////////////////
  // payload types
  ////////////////////////////////////////////////////////////

  typedef logic [slot_width-1:0] sample_t;
  typedef logic [7:0] pcm_byte_t;

  // one frame's worth of outgoing payload, 45 bits
  typedef struct packed {
    logic    cmd_valid;
    logic    [23:0] command;
    sample_t left;
  } out_frame_t;

endpackage
